/* common/bb_consts.svh */
`ifndef BB_CONSTS_SVH
`define BB_CONSTS_SVH

`define BB_FIFO_AW       3     // FIFO depth of 8 symbols
`define BB_TAPS          8     // FIR length
`define BB_TAP_AW        3     // Tap index width
`define BB_BITS_PER_SYM  4     // 16-QAM
`define BB_BIT_CNT_W     2     // Counts bits within a symbol
`define BB_LEVEL_W       4
`define BB_SAMPLE_W      10
`define BB_COEFF_W       8
`define BB_ACC_W         16    // Holds the full sum of eight products
`define BB_ADDR_W        10
`define BB_BIT_SEL_W     3     // Low address bits pick the readback bit
`define BB_IDX_W         7     // High address bits pick the coefficient
`define BB_RATE_W        4
`define BB_SAMPLE_MAX    511
`define BB_SAMPLE_MIN    (-512)

`endif

/* common/bb_pkg.sv */
`include "bb_consts.svh"

package bb_pkg;

    // One component of a 16-QAM symbol, only +-1 and +-3 are used
    typedef logic signed [`BB_LEVEL_W-1:0] level_t;

    // FIFO payload, I in the upper nibble
    typedef struct packed {
        level_t i;
        level_t q;
    } iq_sym_t;

    // Shaped output sample after saturation
    typedef logic signed [`BB_SAMPLE_W-1:0] sample_t;

    // FIR tap weight
    typedef logic signed [`BB_COEFF_W-1:0] coeff_t;

    // Coefficient port address, index in [9:3], bit select in [2:0]
    typedef logic [`BB_ADDR_W-1:0] mem_addr_t;

    typedef enum logic {
        COLLECT,    // Taking bits from the source
        HOLD        // Finished symbol waits for FIFO space
    } map_state_t;

endpackage

/* symbol_mapper/symbol_mapper.sv */
`timescale 1ns/100ps
`include "bb_consts.svh"

module symbol_mapper (
    input  logic            i_data_clk,
    input  logic            i_rst_n,
    input  logic            i_data_in,
    input  logic            i_enable,
    input  logic            i_full,
    output logic            o_push,
    output bb_pkg::iq_sym_t o_sym,
    output logic            o_mapping
);

    bb_pkg::map_state_t              state;
    logic [`BB_BIT_CNT_W-1:0]        bit_cnt;
    logic [`BB_BITS_PER_SYM-2:0]     shreg;
    logic [`BB_BITS_PER_SYM-1:0]     nibble;
    logic                            sym_valid;
    logic                            take_bit;
    logic                            last_bit;

    // Gray rule so adjacent levels differ in one bit
    function automatic bb_pkg::level_t gray_level(input logic [1:0] pair);
        case (pair)
            2'b00:   gray_level = bb_pkg::level_t'(-3);
            2'b01:   gray_level = bb_pkg::level_t'(-1);
            2'b11:   gray_level = bb_pkg::level_t'(1);
            default: gray_level = bb_pkg::level_t'(3);
        endcase
    endfunction

    assign o_mapping = (state == bb_pkg::COLLECT);
    assign take_bit  = i_enable && o_mapping;
    assign last_bit  = take_bit && (bit_cnt == `BB_BIT_CNT_W'(`BB_BITS_PER_SYM - 1));
    assign nibble    = {shreg, i_data_in};    // First bit ends up as MSB
    assign o_push    = sym_valid && !i_full;

    always_ff @(posedge i_data_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= bb_pkg::HOLD;     // Leaves on the first edge with nothing held
            bit_cnt   <= '0;
            sym_valid <= 1'b0;
        end else begin
            if (take_bit) begin
                bit_cnt <= bit_cnt + `BB_BIT_CNT_W'(1);
            end
            if (last_bit) begin
                sym_valid <= 1'b1;
            end else if (o_push) begin
                sym_valid <= 1'b0;
            end
            case (state)
                bb_pkg::COLLECT: begin
                    if (sym_valid && i_full) begin
                        state <= bb_pkg::HOLD;     // Stop taking bits
                    end
                end
                default: begin
                    if (!sym_valid || !i_full) begin
                        state <= bb_pkg::COLLECT;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_data_clk) begin
        if (take_bit) begin
            shreg <= nibble[`BB_BITS_PER_SYM-2:0];
        end
        if (last_bit) begin
            o_sym.i <= gray_level(nibble[3:2]);
            o_sym.q <= gray_level(nibble[1:0]);
        end
    end

    // A symbol that cannot be pushed is kept unchanged
    a_hold_while_full: assert property (@(posedge i_data_clk) disable iff (!i_rst_n)
        sym_valid && i_full |=> sym_valid && $stable(o_sym))
        else $error("symbol_mapper: held symbol lost while FIFO full");

    // Symbol samples stay nonzero in the output
    a_no_zero_level: assert property (@(posedge i_data_clk) disable iff (!i_rst_n)
        o_push |-> (o_sym.i != '0) && (o_sym.q != '0))
        else $error("symbol_mapper: zero level in pushed symbol");

endmodule

/* cdc_fifo/cdc_fifo.sv */
`timescale 1ns/100ps
`include "bb_consts.svh"

module cdc_fifo #(
    parameter int AW = `BB_FIFO_AW
) (
    input  logic            i_wr_clk,
    input  logic            i_rd_clk,
    input  logic            i_rst_n,
    input  logic            i_push,
    input  bb_pkg::iq_sym_t i_wr_data,
    input  logic            i_pop,
    output bb_pkg::iq_sym_t o_rd_data,
    output logic            o_full,
    output logic            o_empty
);

    bb_pkg::iq_sym_t mem [2**AW];

    // Pointers carry one extra bit to tell full from empty
    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_next;
    logic [AW:0] wr_gray;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_next;
    logic [AW:0] rd_gray;
    logic [AW:0] rd_gray_w1;    // Read pointer, write domain
    logic [AW:0] rd_gray_w2;
    logic [AW:0] wr_gray_r1;    // Write pointer, read domain
    logic [AW:0] wr_gray_r2;
    logic        do_push;
    logic        do_pop;

    function automatic logic [AW:0] to_gray(input logic [AW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    assign do_push     = i_push && !o_full;
    assign do_pop      = i_pop && !o_empty;
    assign wr_bin_next = wr_bin + {{AW{1'b0}}, 1'b1};
    assign rd_bin_next = rd_bin + {{AW{1'b0}}, 1'b1};

    always_ff @(posedge i_wr_clk) begin
        if (do_push) begin
            mem[wr_bin[AW-1:0]] <= i_wr_data;
        end
    end

    always_ff @(posedge i_wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (do_push) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= to_gray(wr_bin_next);
        end
    end

    always_ff @(posedge i_wr_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    // Full when the top two Gray bits differ and the rest match
    assign o_full = (wr_gray == {~rd_gray_w2[AW:AW-1], rd_gray_w2[AW-2:0]});

    always_ff @(posedge i_rd_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (do_pop) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= to_gray(rd_bin_next);
        end
    end

    always_ff @(posedge i_rd_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    assign o_empty   = (rd_gray == wr_gray_r2);
    assign o_rd_data = mem[rd_bin[AW-1:0]];     // Show-ahead

    a_no_push_full: assert property (@(posedge i_wr_clk) disable iff (!i_rst_n)
        i_push |-> !o_full)
        else $error("cdc_fifo: push while full");

    a_no_pop_empty: assert property (@(posedge i_rd_clk) disable iff (!i_rst_n)
        i_pop |-> !o_empty)
        else $error("cdc_fifo: pop while empty");

endmodule

/* pulse_shaper/coeff_ram.sv */
`timescale 1ns/100ps
`include "bb_consts.svh"

module coeff_ram (
    input  logic                           i_dsp_clk,
    input  logic                           i_rst_n,
    input  logic                           i_rw,
    input  bb_pkg::mem_addr_t              i_mem_addr,
    input  bb_pkg::coeff_t                 i_coeff_in,
    output bb_pkg::coeff_t [`BB_TAPS-1:0]  o_coeffs,
    output logic                           o_mem_read_out
);

    logic [`BB_IDX_W-1:0]     coeff_idx;
    logic [`BB_BIT_SEL_W-1:0] bit_sel;
    logic                     idx_valid;
    bb_pkg::coeff_t           sel_coeff;

    assign coeff_idx = i_mem_addr[`BB_ADDR_W-1:`BB_BIT_SEL_W];
    assign bit_sel   = i_mem_addr[`BB_BIT_SEL_W-1:0];
    assign idx_valid = (coeff_idx < `BB_IDX_W'(`BB_TAPS));     // Upper indices are unmapped
    assign sel_coeff = o_coeffs[coeff_idx[`BB_TAP_AW-1:0]];

    always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_coeffs       <= '0;
            o_mem_read_out <= 1'b0;
        end else begin
            if (i_rw && idx_valid) begin
                o_coeffs[coeff_idx[`BB_TAP_AW-1:0]] <= i_coeff_in;
            end
            // Value before any write in the same cycle
            o_mem_read_out <= idx_valid && sel_coeff[bit_sel];
        end
    end

endmodule

/* pulse_shaper/pulse_shaper.sv */
`timescale 1ns/100ps
`include "bb_consts.svh"

module pulse_shaper (
    input  logic                  i_dsp_clk,
    input  logic                  i_rst_n,
    input  logic [`BB_RATE_W-1:0] i_sample_rate,
    input  logic                  i_rw,
    input  bb_pkg::mem_addr_t     i_mem_addr,
    input  bb_pkg::coeff_t        i_coeff_in,
    input  bb_pkg::iq_sym_t       i_fifo_data,
    input  logic                  i_fifo_empty,
    output logic                  o_pop,
    output bb_pkg::sample_t       o_i_out,
    output bb_pkg::sample_t       o_q_out,
    output logic                  o_mem_read_out
);

    bb_pkg::coeff_t [`BB_TAPS-1:0] coeffs;
    bb_pkg::level_t [`BB_TAPS-1:0] line_i;     // Tap 0 is the newest sample
    bb_pkg::level_t [`BB_TAPS-1:0] line_q;
    logic [`BB_RATE_W-1:0]         phase;
    logic [`BB_RATE_W-1:0]         phase_last;
    logic                          boundary;
    bb_pkg::iq_sym_t               sym_in;
    logic signed [`BB_ACC_W-1:0]   acc_i;
    logic signed [`BB_ACC_W-1:0]   acc_q;

    function automatic bb_pkg::sample_t saturate(input logic signed [`BB_ACC_W-1:0] v);
        if (v > `BB_SAMPLE_MAX) begin
            return bb_pkg::sample_t'(`BB_SAMPLE_MAX);
        end
        if (v < `BB_SAMPLE_MIN) begin
            return bb_pkg::sample_t'(`BB_SAMPLE_MIN);
        end
        return bb_pkg::sample_t'(v);
    endfunction

    coeff_ram u_coeff_ram (
        .i_dsp_clk      (i_dsp_clk),
        .i_rst_n        (i_rst_n),
        .i_rw           (i_rw),
        .i_mem_addr     (i_mem_addr),
        .i_coeff_in     (i_coeff_in),
        .o_coeffs       (coeffs),
        .o_mem_read_out (o_mem_read_out)
    );

    // Rate 0 wraps to 15 here, giving N = 16
    assign phase_last = i_sample_rate - `BB_RATE_W'(1);
    assign boundary   = (phase == '0);
    assign o_pop      = boundary && !i_fifo_empty;
    assign sym_in     = o_pop ? i_fifo_data : '0;    // Zero stuffing and underflow

    always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase <= '0;
        end else if (phase >= phase_last) begin
            phase <= '0;    // Also resyncs after a rate change
        end else begin
            phase <= phase + `BB_RATE_W'(1);
        end
    end

    always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_i <= '0;
            line_q <= '0;
        end else begin
            line_i <= {line_i[`BB_TAPS-2:0], sym_in.i};
            line_q <= {line_q[`BB_TAPS-2:0], sym_in.q};
        end
    end

    always_comb begin
        acc_i = '0;
        acc_q = '0;
        for (int k = 0; k < `BB_TAPS; k++) begin
            acc_i = acc_i + $signed(coeffs[k]) * $signed(line_i[k]);
            acc_q = acc_q + $signed(coeffs[k]) * $signed(line_q[k]);
        end
    end

    always_ff @(posedge i_dsp_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_i_out <= '0;
            o_q_out <= '0;
        end else begin
            o_i_out <= saturate(acc_i);
            o_q_out <= saturate(acc_q);
        end
    end

endmodule

/* source/baseband_dsp.sv */
`timescale 1ns/100ps
`include "bb_consts.svh"

module baseband_dsp (
    input  logic                  i_data_clk,
    input  logic                  i_dsp_clk,
    input  logic                  i_rst_n,
    input  logic                  i_data_in,
    input  logic                  i_enable,
    input  logic                  i_rw,
    input  bb_pkg::mem_addr_t     i_mem_addr,
    input  bb_pkg::coeff_t        i_coeff_in,
    input  logic [`BB_RATE_W-1:0] i_sample_rate,
    output logic                  o_mapping,
    output logic                  o_mem_read_out,
    output bb_pkg::sample_t       o_i_out,
    output bb_pkg::sample_t       o_q_out
);

    logic            sym_push;
    logic            sym_pop;
    logic            fifo_full;     // Data clock domain
    logic            fifo_empty;    // DSP clock domain
    bb_pkg::iq_sym_t map_sym;
    bb_pkg::iq_sym_t fifo_sym;

    symbol_mapper u_symbol_mapper (
        .i_data_clk (i_data_clk),
        .i_rst_n    (i_rst_n),
        .i_data_in  (i_data_in),
        .i_enable   (i_enable),
        .i_full     (fifo_full),
        .o_push     (sym_push),
        .o_sym      (map_sym),
        .o_mapping  (o_mapping)
    );

    cdc_fifo #(
        .AW (`BB_FIFO_AW)
    ) u_cdc_fifo (
        .i_wr_clk   (i_data_clk),
        .i_rd_clk   (i_dsp_clk),
        .i_rst_n    (i_rst_n),
        .i_push     (sym_push),
        .i_wr_data  (map_sym),
        .i_pop      (sym_pop),
        .o_rd_data  (fifo_sym),
        .o_full     (fifo_full),
        .o_empty    (fifo_empty)
    );

    pulse_shaper u_pulse_shaper (
        .i_dsp_clk      (i_dsp_clk),
        .i_rst_n        (i_rst_n),
        .i_sample_rate  (i_sample_rate),
        .i_rw           (i_rw),
        .i_mem_addr     (i_mem_addr),
        .i_coeff_in     (i_coeff_in),
        .i_fifo_data    (fifo_sym),
        .i_fifo_empty   (fifo_empty),
        .o_pop          (sym_pop),
        .o_i_out        (o_i_out),
        .o_q_out        (o_q_out),
        .o_mem_read_out (o_mem_read_out)
    );

endmodule

/* tb/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen #(
    parameter real PERIOD = 20.0,
    parameter real OFFSET = 0.0     // Time of the first rising edge
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        #(OFFSET);
        forever begin
            o_clk = 1'b1;
            #(PERIOD / 2.0);
            o_clk = 1'b0;
            #(PERIOD / 2.0);
        end
    end

endmodule

/* tb/tb_baseband_dsp.sv */
`timescale 1ns/100ps
`include "bb_consts.svh"

module tb_baseband_dsp;

    localparam int T3_SYMS    = 16;
    localparam int T4_SYMS    = 24;
    localparam int T5_SYMS    = 40;
    localparam int TOTAL_BITS = `BB_BITS_PER_SYM * (T3_SYMS + T4_SYMS + T5_SYMS);
    // Worst case a bit waits 4 x 16 DSP cycles of 20 ns
    localparam int TIMEOUT_NS = TOTAL_BITS * 4 * 16 * 20 + 50000;
    localparam logic [3:0] SAT_NIBBLE = 4'b1001;    // I = +3, Q = -1
    localparam int SAT_COEFF  = 127;

    logic                  data_clk;
    logic                  dsp_clk;
    logic                  rst_n;
    logic                  data_in;
    logic                  enable;
    logic                  rw;
    bb_pkg::mem_addr_t     mem_addr;
    bb_pkg::coeff_t        coeff_in;
    logic [`BB_RATE_W-1:0] sample_rate;
    logic                  mapping;
    logic                  mem_read_out;
    bb_pkg::sample_t       i_out;
    bb_pkg::sample_t       q_out;

    int             seed = 78098;
    int             errors = 0;
    int             checks = 0;
    int             total_taken = 0;
    logic [3:0]     bit_buf = '0;
    int             exp_i[$];
    int             exp_q[$];
    bit             seq_check = 1'b0;
    bit             sat_check = 1'b0;
    bit             stall_seen = 1'b0;
    int             sat_seen = 0;
    int             exp_sat_i;
    int             exp_sat_q;
    string          test_name = "reset";
    bb_pkg::coeff_t coeff_model [`BB_TAPS];

    tb_clkgen #(.PERIOD(20.0), .OFFSET(10.0)) u_data_clk (.o_clk(data_clk));
    tb_clkgen #(.PERIOD(20.0), .OFFSET(17.0)) u_dsp_clk (.o_clk(dsp_clk));

    baseband_dsp DUT (
        .i_data_clk     (data_clk),
        .i_dsp_clk      (dsp_clk),
        .i_rst_n        (rst_n),
        .i_data_in      (data_in),
        .i_enable       (enable),
        .i_rw           (rw),
        .i_mem_addr     (mem_addr),
        .i_coeff_in     (coeff_in),
        .i_sample_rate  (sample_rate),
        .o_mapping      (mapping),
        .o_mem_read_out (mem_read_out),
        .o_i_out        (i_out),
        .o_q_out        (q_out)
    );

    // Gray pair to binary index, then index to level -3, -1, +1, +3
    function automatic int pair_to_level(input logic [1:0] pair);
        int idx;
        idx = int'({pair[1], pair[1] ^ pair[0]});
        return 2 * idx - 3;
    endfunction

    function automatic int clamp_to_sample(input int v);
        if (v > 511) begin
            return 511;
        end
        if (v < -512) begin
            return -512;
        end
        return v;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic check_outputs_zero(input string when);
        check_value({when, " o_mapping"}, 0, mapping);
        check_value({when, " o_mem_read_out"}, 0, mem_read_out);
        check_value({when, " o_i_out"}, 0, i_out);
        check_value({when, " o_q_out"}, 0, q_out);
    endtask

    task automatic set_rate(input logic [`BB_RATE_W-1:0] rate);
        @(posedge dsp_clk);
        #2;
        sample_rate = rate;
    endtask

    task automatic write_coeff(input int idx, input bb_pkg::coeff_t value);
        @(posedge dsp_clk);
        #2;
        rw       = 1'b1;
        mem_addr = {`BB_IDX_W'(idx), `BB_BIT_SEL_W'(0)};
        coeff_in = value;
        @(posedge dsp_clk);
        #2;
        rw = 1'b0;
    endtask

    task automatic read_bit(input int idx, input int bit_idx, output logic value);
        @(posedge dsp_clk);
        #2;
        mem_addr = {`BB_IDX_W'(idx), `BB_BIT_SEL_W'(bit_idx)};
        @(posedge dsp_clk);     // Readback registered here
        @(negedge dsp_clk);
        value = mem_read_out;
    endtask

    // Offers bits until enough symbols are taken, ending on a symbol boundary
    task automatic drive_bits(input int n_syms, input bit need_stall, input bit fixed);
        int  start;
        int  taken;
        int  r;
        bit  done;
        start = total_taken;
        done  = 1'b0;
        while (!done) begin
            @(posedge data_clk);
            #2;
            if (!mapping) begin
                stall_seen = 1'b1;
            end
            taken = total_taken - start;
            done  = (taken >= n_syms * `BB_BITS_PER_SYM) &&
                    (taken % `BB_BITS_PER_SYM == 0) && (stall_seen || !need_stall);
            if (done) begin
                enable = 1'b0;
            end else begin
                r       = $random(seed);
                enable  = 1'b1;
                data_in = fixed ? SAT_NIBBLE[3 - (total_taken % `BB_BITS_PER_SYM)] : r[0];
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_i.size() != 0) begin
            @(posedge dsp_clk);
        end
        repeat (64) @(posedge dsp_clk);     // Quiet time exposes repeated symbols
    endtask

    // Inputs and o_mapping are steady from here to the next rising edge
    always @(negedge data_clk) begin
        if (rst_n && enable && mapping) begin
            bit_buf = {bit_buf[2:0], data_in};
            total_taken++;
            if (total_taken % `BB_BITS_PER_SYM == 0) begin
                exp_i.push_back(pair_to_level(bit_buf[3:2]));
                exp_q.push_back(pair_to_level(bit_buf[1:0]));
            end
        end
    end

    always @(negedge dsp_clk) begin
        int lvl_i;
        int lvl_q;
        if (rst_n && (i_out != '0 || q_out != '0)) begin
            if (seq_check && exp_i.size() == 0) begin
                errors++;
                $display("%s: output pair (%0d, %0d) at %0t has no symbol left to match",
                         test_name, i_out, q_out, $time);
            end else if (seq_check) begin
                lvl_i = exp_i.pop_front();
                lvl_q = exp_q.pop_front();
                check_value({test_name, " I"}, clamp_to_sample(lvl_i), i_out);  // Tap 0 weight 1
                check_value({test_name, " Q"}, clamp_to_sample(lvl_q), q_out);
            end else if (sat_check) begin
                check_value("saturation I", exp_sat_i, i_out);
                check_value("saturation Q", exp_sat_q, q_out);
                sat_seen++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped making progress", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int   r;
        logic got;
        rst_n       = 1'b0;
        data_in     = 1'b0;
        enable      = 1'b0;
        rw          = 1'b0;
        mem_addr    = '0;
        coeff_in    = '0;
        sample_rate = `BB_RATE_W'(6);

        repeat (3) @(posedge data_clk);
        #1;
        check_outputs_zero("reset active");
        #1;
        rst_n = 1'b1;       // 2 ns after the data edge, 5 ns before the DSP edge
        @(posedge dsp_clk);
        #2;
        check_outputs_zero("first cycle after reset");
        @(posedge data_clk);
        #2;
        check_value("o_mapping after reset", 1, mapping);

        test_name = "coefficient port";
        for (int k = 0; k < `BB_TAPS; k++) begin
            r = $random(seed);
            coeff_model[k] = r[7:0];
            write_coeff(k, coeff_model[k]);
        end
        for (int k = 0; k < `BB_TAPS; k++) begin
            for (int b = 0; b < 8; b++) begin
                read_bit(k, b, got);
                check_value($sformatf("coeff %0d bit %0d", k, b), coeff_model[k][b], got);
            end
        end
        write_coeff(9, 8'h7f);      // Index 9 is unmapped so tap 1 keeps its value
        for (int b = 0; b < 8; b++) begin
            read_bit(9, b, got);
            check_value($sformatf("coeff 9 bit %0d", b), 0, got);
            read_bit(1, b, got);
            check_value($sformatf("coeff 1 kept bit %0d", b), coeff_model[1][b], got);
        end

        for (int k = 0; k < `BB_TAPS; k++) begin
            write_coeff(k, bb_pkg::coeff_t'(k == 0));
        end
        set_rate(`BB_RATE_W'(6));
        test_name = "mapping order";
        seq_check = 1'b1;
        stall_seen = 1'b0;
        drive_bits(T3_SYMS, 1'b0, 1'b0);
        wait_drain();

        set_rate(`BB_RATE_W'(15));
        test_name  = "back-pressure";
        stall_seen = 1'b0;
        drive_bits(T4_SYMS, 1'b1, 1'b0);
        wait_drain();
        seq_check = 1'b0;

        test_name = "saturation";
        write_coeff(0, bb_pkg::coeff_t'(SAT_COEFF));
        write_coeff(4, bb_pkg::coeff_t'(SAT_COEFF));
        exp_sat_i  = clamp_to_sample(2 * SAT_COEFF * pair_to_level(SAT_NIBBLE[3:2]));
        exp_sat_q  = clamp_to_sample(2 * SAT_COEFF * pair_to_level(SAT_NIBBLE[1:0]));
        set_rate('0);       // N = 16 drains slowly so the FIFO fills
        stall_seen = 1'b0;
        fork
            drive_bits(T5_SYMS, 1'b1, 1'b1);
            begin
                wait (stall_seen);
                set_rate(`BB_RATE_W'(4));
                repeat (2 * `BB_TAPS) @(posedge dsp_clk);    // Flush the old spacing
                sat_check = 1'b1;
            end
        join
        sat_check = 1'b0;
        if (sat_seen == 0) begin
            errors++;
            $display("saturation: no output pair was seen while the FIFO was primed");
        end
        exp_i.delete();
        exp_q.delete();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+common
common/bb_pkg.sv
symbol_mapper/symbol_mapper.sv
cdc_fifo/cdc_fifo.sv
pulse_shaper/coeff_ram.sv
pulse_shaper/pulse_shaper.sv
source/baseband_dsp.sv
tb/tb_clkgen.sv
tb/tb_baseband_dsp.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the baseband testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_baseband_dsp -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run_sim.sh: failures found in sim.log"
    exit 1
fi

echo "run_sim.sh: no failures found in sim.log"
exit 0
